//--- common/rvPkg.sv
package rvPkg;

	localparam int XLEN = 32;

	typedef logic [4:0] regIdxT;

	// ALU codes follow the numbering the bus and decode logic have always used.
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0, ALU_SUB = 4'd1, ALU_OR = 4'd2, ALU_XOR = 4'd3, ALU_AND = 4'd4,
		ALU_SLL = 4'd5, ALU_SRA = 4'd6, ALU_SLTU = 4'd7, ALU_SLT = 4'd8, ALU_SRL = 4'd9
	} aluOpE;

	typedef enum logic [5:0] {
		CU_LUI = 6'd0, CU_AUIPC = 6'd1, CU_JAL = 6'd2, CU_JALR = 6'd3,
		CU_BEQ = 6'd4, CU_BNE = 6'd5, CU_BLT = 6'd6, CU_BGE = 6'd7, CU_BLTU = 6'd8,
		CU_BGEU = 6'd9,
		CU_LB = 6'd10, CU_LH = 6'd11, CU_LW = 6'd12, CU_LBU = 6'd13, CU_LHU = 6'd14,
		CU_SB = 6'd15, CU_SH = 6'd16, CU_SW = 6'd17,
		CU_ADDI = 6'd18, CU_SLTI = 6'd19, CU_SLTIU = 6'd20, CU_XORI = 6'd22, CU_ORI = 6'd23,
		CU_ANDI = 6'd24, CU_SLLI = 6'd25, CU_SRLI = 6'd26, CU_SRAI = 6'd27,
		CU_ADD = 6'd28, CU_SUB = 6'd29, CU_SLL = 6'd30, CU_SLT = 6'd31, CU_SLTU = 6'd32,
		CU_XOR = 6'd33, CU_SRL = 6'd34, CU_SRA = 6'd35, CU_OR = 6'd36, CU_AND = 6'd37,
		CU_ILLEGAL = 6'd38, CU_HALT = 6'd39
	} cuOpE;

	typedef struct packed {
		cuOpE cuOp;
		aluOpE aluOp;
		regIdxT rs1;
		regIdxT rs2;
		regIdxT rd;
		logic regWrite;
		logic aluSrc;
		logic memRead;
		logic memWrite;
		logic [XLEN-1:0] imm; // Sign-extended; branch and JAL offsets are stored halved.
	} decodeT;

	typedef struct packed {
		logic read;
		logic write;
		logic [XLEN-1:0] adr;
		logic [XLEN-1:0] dat;
	} wbReqT;

	typedef struct packed {
		logic busy;
		logic [XLEN-1:0] dat;
	} wbRspT;

	typedef struct packed {
		logic [XLEN-1:0] adr;
		logic [XLEN-1:0] dat;
		logic [3:0] sel;
		logic we;
		logic stb;
		logic cyc;
	} wbMasterT;

	localparam logic [XLEN-1:0] HALT_WORD = '1;

endpackage

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder
	import rvPkg::*;
(
	input logic [XLEN-1:0] instr_i,
	output decodeT ctrl_o
);

	logic [2:0] funct3;
	logic isReg;
	logic [XLEN-1:0] immI;
	logic [XLEN-1:0] immS;
	logic [XLEN-1:0] immB;
	logic [XLEN-1:0] immJ;
	logic [XLEN-1:0] immU;

	assign funct3 = instr_i[14:12];
	assign isReg = instr_i[5]; // Register form of the ALU opcodes.
	assign immI = {{20{instr_i[31]}}, instr_i[31:20]};
	assign immS = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign immB = {{21{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8]};
	assign immJ = {{13{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21]};
	assign immU = {instr_i[31:12], 12'b0};

	always_comb begin
		ctrl_o = '0;
		ctrl_o.cuOp = CU_ILLEGAL;
		ctrl_o.aluOp = ALU_ADD;
		ctrl_o.rs1 = instr_i[19:15];
		ctrl_o.rd = instr_i[11:7];
		if (instr_i == HALT_WORD) begin
			ctrl_o.cuOp = CU_HALT;
		end else begin
			case (instr_i[6:0])
				7'b0110111: begin
					ctrl_o.cuOp = CU_LUI;
					ctrl_o.imm = immU;
					ctrl_o.regWrite = 1'b1;
				end
				7'b0010111: begin
					ctrl_o.cuOp = CU_AUIPC;
					ctrl_o.imm = immU;
					ctrl_o.regWrite = 1'b1;
				end
				7'b1101111: begin
					ctrl_o.cuOp = CU_JAL;
					ctrl_o.imm = immJ;
					ctrl_o.regWrite = 1'b1;
				end
				7'b1100111: begin
					ctrl_o.cuOp = CU_JALR;
					ctrl_o.imm = immI;
					ctrl_o.regWrite = 1'b1;
				end
				7'b1100011: begin
					ctrl_o.rs2 = instr_i[24:20];
					ctrl_o.imm = immB;
					ctrl_o.aluOp = ALU_SUB; // Flags of rs1 - rs2 decide the branch.
					case (funct3)
						3'b000: ctrl_o.cuOp = CU_BEQ;
						3'b001: ctrl_o.cuOp = CU_BNE;
						3'b100: ctrl_o.cuOp = CU_BLT;
						3'b101: ctrl_o.cuOp = CU_BGE;
						3'b110: ctrl_o.cuOp = CU_BLTU;
						3'b111: ctrl_o.cuOp = CU_BGEU;
						default: ctrl_o.cuOp = CU_ILLEGAL;
					endcase
				end
				7'b0000011: begin
					ctrl_o.imm = immI;
					ctrl_o.aluSrc = 1'b1;
					ctrl_o.regWrite = 1'b1;
					ctrl_o.memRead = 1'b1;
					case (funct3)
						3'b000: ctrl_o.cuOp = CU_LB;
						3'b001: ctrl_o.cuOp = CU_LH;
						3'b010: ctrl_o.cuOp = CU_LW;
						3'b100: ctrl_o.cuOp = CU_LBU;
						3'b101: ctrl_o.cuOp = CU_LHU;
						default: ctrl_o.cuOp = CU_ILLEGAL;
					endcase
				end
				7'b0100011: begin
					ctrl_o.rs2 = instr_i[24:20];
					ctrl_o.imm = immS;
					ctrl_o.aluSrc = 1'b1;
					ctrl_o.memWrite = 1'b1;
					case (funct3)
						3'b000: ctrl_o.cuOp = CU_SB;
						3'b001: ctrl_o.cuOp = CU_SH;
						3'b010: ctrl_o.cuOp = CU_SW;
						default: ctrl_o.cuOp = CU_ILLEGAL;
					endcase
				end
				7'b0010011, 7'b0110011: begin
					ctrl_o.rs2 = isReg ? instr_i[24:20] : 5'd0;
					ctrl_o.imm = immI;
					ctrl_o.aluSrc = !isReg;
					ctrl_o.regWrite = 1'b1;
					case (funct3)
						3'b000: begin
							ctrl_o.aluOp = (isReg && instr_i[30]) ? ALU_SUB : ALU_ADD;
							ctrl_o.cuOp = isReg ? (instr_i[30] ? CU_SUB : CU_ADD) : CU_ADDI;
						end
						3'b001: begin
							ctrl_o.aluOp = ALU_SLL;
							ctrl_o.cuOp = isReg ? CU_SLL : CU_SLLI;
						end
						3'b010: begin
							ctrl_o.aluOp = ALU_SLT;
							ctrl_o.cuOp = isReg ? CU_SLT : CU_SLTI;
						end
						3'b011: begin
							ctrl_o.aluOp = ALU_SLTU;
							ctrl_o.cuOp = isReg ? CU_SLTU : CU_SLTIU;
						end
						3'b100: begin
							ctrl_o.aluOp = ALU_XOR;
							ctrl_o.cuOp = isReg ? CU_XOR : CU_XORI;
						end
						3'b101: begin
							ctrl_o.aluOp = instr_i[30] ? ALU_SRA : ALU_SRL;
							if (isReg)
								ctrl_o.cuOp = instr_i[30] ? CU_SRA : CU_SRL;
							else
								ctrl_o.cuOp = instr_i[30] ? CU_SRAI : CU_SRLI;
						end
						3'b110: begin
							ctrl_o.aluOp = ALU_OR;
							ctrl_o.cuOp = isReg ? CU_OR : CU_ORI;
						end
						default: begin
							ctrl_o.aluOp = ALU_AND;
							ctrl_o.cuOp = isReg ? CU_AND : CU_ANDI;
						end
					endcase
				end
				default: ctrl_o.cuOp = CU_ILLEGAL;
			endcase
		end
		// An illegal word must leave the registers and memory untouched.
		if (ctrl_o.cuOp == CU_ILLEGAL) begin
			ctrl_o.regWrite = 1'b0;
			ctrl_o.memRead = 1'b0;
			ctrl_o.memWrite = 1'b0;
		end
	end

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu
	import rvPkg::*;
(
	input logic [XLEN-1:0] a_i,
	input logic [XLEN-1:0] b_i,
	input aluOpE op_i,
	output logic [XLEN-1:0] result_o,
	output logic negative_o,
	output logic zero_o
);

	logic [4:0] shamt;

	assign shamt = b_i[4:0];

	always_comb begin
		case (op_i)
			ALU_ADD: result_o = a_i + b_i;
			ALU_SUB: result_o = a_i - b_i;
			ALU_OR: result_o = a_i | b_i;
			ALU_XOR: result_o = a_i ^ b_i;
			ALU_AND: result_o = a_i & b_i;
			ALU_SLL: result_o = a_i << shamt;
			ALU_SRA: result_o = $signed(a_i) >>> shamt;
			ALU_SRL: result_o = a_i >> shamt;
			ALU_SLT: result_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
			ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, a_i < b_i};
			default: result_o = '0;
		endcase
	end

	assign negative_o = result_o[XLEN-1];
	assign zero_o = (result_o == '0); // Branches read this after a subtract.

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ps

module regFile
	import rvPkg::*;
(
	input logic clk,
	input logic nRST,
	input logic retire_i,
	input decodeT ctrl_i,
	input logic [XLEN-1:0] wrData_i,
	output logic [XLEN-1:0] rs1Data_o,
	output logic [XLEN-1:0] rs2Data_o
);

	logic [XLEN-1:0] regs [1:31]; // x0 has no storage.

	always_ff @(posedge clk or negedge nRST) begin
		if (!nRST) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (retire_i && ctrl_i.regWrite && ctrl_i.rd != 5'd0) begin
			regs[ctrl_i.rd] <= wrData_i;
		end
	end

	assign rs1Data_o = (ctrl_i.rs1 == 5'd0) ? '0 : regs[ctrl_i.rs1];
	assign rs2Data_o = (ctrl_i.rs2 == 5'd0) ? '0 : regs[ctrl_i.rs2];

endmodule

//--- verilog/pcUnit.sv
`timescale 1ns/1ps

module pcUnit
	import rvPkg::*;
#(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input logic clk,
	input logic nRST,
	input logic enable_i,
	input logic retire_i,
	input decodeT ctrl_i,
	input logic [XLEN-1:0] rs1Data_i,
	input logic negative_i,
	input logic zero_i,
	output logic [XLEN-1:0] pc_o
);

	logic [XLEN-1:0] pcQ;
	logic [XLEN-1:0] pcNext;
	logic [XLEN-1:0] target;
	logic taken;

	assign target = pcQ + (ctrl_i.imm << 1); // Offsets come in halved.

	always_comb begin
		case (ctrl_i.cuOp)
			CU_BEQ: taken = zero_i;
			CU_BNE: taken = !zero_i;
			CU_BLT, CU_BLTU: taken = negative_i;
			CU_BGE, CU_BGEU: taken = !negative_i;
			default: taken = 1'b0;
		endcase
		if (ctrl_i.cuOp == CU_JALR)
			pcNext = rs1Data_i + ctrl_i.imm;
		else if (ctrl_i.cuOp == CU_JAL || taken)
			pcNext = target;
		else
			pcNext = pcQ + XLEN'(4);
	end

	always_ff @(posedge clk or negedge nRST) begin
		if (!nRST)
			pcQ <= RESET_PC;
		else if (!enable_i)
			pcQ <= RESET_PC;
		else if (retire_i)
			pcQ <= pcNext;
	end

	assign pc_o = pcQ;

endmodule

//--- verilog/writeBack.sv
`timescale 1ns/1ps

module writeBack
	import rvPkg::*;
(
	input decodeT ctrl_i,
	input logic [XLEN-1:0] aluResult_i,
	input logic [XLEN-1:0] load_i,
	input logic [XLEN-1:0] pc_i,
	output logic [XLEN-1:0] wrData_o
);

	always_comb begin
		case (ctrl_i.cuOp)
			CU_LB: wrData_o = {{(XLEN-8){load_i[7]}}, load_i[7:0]};
			CU_LH: wrData_o = {{(XLEN-16){load_i[15]}}, load_i[15:0]};
			CU_LW: wrData_o = load_i;
			CU_LBU: wrData_o = {{(XLEN-8){1'b0}}, load_i[7:0]};
			CU_LHU: wrData_o = {{(XLEN-16){1'b0}}, load_i[15:0]};
			CU_LUI: wrData_o = ctrl_i.imm;
			CU_AUIPC: wrData_o = pc_i + ctrl_i.imm;
			CU_JAL, CU_JALR: wrData_o = pc_i + XLEN'(4); // Link address.
			default: wrData_o = aluResult_i;
		endcase
	end

endmodule

//--- bus/coreSequencer.sv
`timescale 1ns/1ps

module coreSequencer
	import rvPkg::*;
#(
	parameter logic [XLEN-1:0] DATA_BASE = '0
) (
	input logic clk,
	input logic nRST,
	input logic enable_i,
	input logic [XLEN-1:0] pc_i,
	input decodeT ctrl_i,
	input logic [XLEN-1:0] aluResult_i,
	input logic [XLEN-1:0] storeData_i,
	input wbRspT rsp_i,
	output wbReqT req_o,
	output logic [XLEN-1:0] instr_o,
	output logic [XLEN-1:0] load_o,
	output logic retire_o,
	output logic halted_o
);

	typedef enum logic [2:0] {
		SEQ_IDLE, SEQ_FETCH, SEQ_EXEC, SEQ_DATA, SEQ_RETIRE, SEQ_HALTED
	} seqStateE;

	seqStateE state;
	logic readQ;
	logic writeQ;
	logic busDone;
	logic [XLEN-1:0] adrQ;
	logic [XLEN-1:0] datQ;
	logic [XLEN-1:0] instrQ;
	logic [XLEN-1:0] loadQ;

	// A strobe still up means the manager has not yet taken the request.
	assign busDone = !rsp_i.busy && !readQ && !writeQ;

	always_ff @(posedge clk or negedge nRST) begin
		if (!nRST) begin
			state <= SEQ_IDLE;
			readQ <= 1'b0;
			writeQ <= 1'b0;
		end else if (!enable_i) begin
			state <= SEQ_IDLE;
			readQ <= 1'b0;
			writeQ <= 1'b0;
		end else begin
			readQ <= 1'b0;
			writeQ <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (!rsp_i.busy) begin
						readQ <= 1'b1;
						state <= SEQ_FETCH;
					end
				end
				SEQ_FETCH: if (busDone) state <= SEQ_EXEC;
				SEQ_EXEC: begin
					if (ctrl_i.cuOp == CU_HALT) begin
						state <= SEQ_HALTED;
					end else if (ctrl_i.memRead) begin
						readQ <= 1'b1;
						state <= SEQ_DATA;
					end else if (ctrl_i.memWrite) begin
						writeQ <= 1'b1;
						state <= SEQ_DATA;
					end else begin
						state <= SEQ_RETIRE;
					end
				end
				SEQ_DATA: if (busDone) state <= SEQ_RETIRE;
				SEQ_RETIRE: state <= SEQ_IDLE; // PC is updated by now, so fetch from idle.
				SEQ_HALTED: state <= SEQ_HALTED;
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == SEQ_IDLE) begin
			adrQ <= pc_i;
			datQ <= '0;
		end else if (state == SEQ_EXEC) begin
			adrQ <= aluResult_i + DATA_BASE;
			datQ <= storeData_i;
		end
		if (state == SEQ_FETCH && busDone)
			instrQ <= rsp_i.dat;
		if (state == SEQ_DATA && busDone && ctrl_i.memRead)
			loadQ <= rsp_i.dat;
	end

	assign req_o = '{read: readQ, write: writeQ, adr: adrQ, dat: datQ};
	assign instr_o = instrQ;
	assign load_o = loadQ;
	assign retire_o = (state == SEQ_RETIRE);
	assign halted_o = (state == SEQ_HALTED);

endmodule

//--- bus/wbManager.sv
`timescale 1ns/1ps

module wbManager
	import rvPkg::*;
(
	input logic clk,
	input logic nRST,
	input wbReqT req_i,
	input logic [XLEN-1:0] datI_i,
	input logic ackI_i,
	output wbRspT rsp_o,
	output wbMasterT wb_o
);

	typedef enum logic [1:0] {
		MGR_IDLE, MGR_WRITE, MGR_READ
	} mgrStateE;

	mgrStateE state;
	wbMasterT wbQ;
	logic busyQ;
	logic [XLEN-1:0] rdDataQ;

	always_ff @(posedge clk or negedge nRST) begin
		if (!nRST) begin
			state <= MGR_IDLE;
			wbQ <= '0;
			busyQ <= 1'b0;
		end else begin
			case (state)
				MGR_IDLE: begin
					if (req_i.write && !req_i.read) begin
						state <= MGR_WRITE;
						busyQ <= 1'b1;
						wbQ.adr <= req_i.adr;
						wbQ.dat <= req_i.dat;
					end else if (req_i.read && !req_i.write) begin
						state <= MGR_READ;
						busyQ <= 1'b1;
						wbQ.adr <= req_i.adr;
						wbQ.dat <= '0;
					end
				end
				MGR_WRITE, MGR_READ: begin
					if (!wbQ.cyc) begin
						wbQ.cyc <= 1'b1; // Bus cycle opens one clock after busy.
						wbQ.stb <= 1'b1;
						wbQ.sel <= 4'hF;
						wbQ.we <= (state == MGR_WRITE);
					end else if (ackI_i) begin
						wbQ.cyc <= 1'b0;
						wbQ.stb <= 1'b0;
						wbQ.sel <= 4'h0;
						wbQ.we <= 1'b0;
						busyQ <= 1'b0;
						state <= MGR_IDLE;
					end
				end
				default: state <= MGR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == MGR_READ && wbQ.stb && ackI_i)
			rdDataQ <= datI_i;
	end

	assign rsp_o = '{busy: busyQ, dat: rdDataQ};
	assign wb_o = wbQ;

endmodule

//--- verilog/rvCore.sv
`timescale 1ns/1ps

module rvCore
	import rvPkg::*;
#(
	parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0000,
	parameter logic [XLEN-1:0] DATA_BASE = 32'h0000_1000
) (
	input logic clk,
	input logic nRST,
	input logic enable_i,
	input logic [XLEN-1:0] datI_i,
	input logic ackI_i,
	output wbMasterT wb_o,
	output logic halted_o
);

	decodeT ctrl;
	wbReqT req;
	wbRspT rsp;
	logic [XLEN-1:0] instr;
	logic [XLEN-1:0] rs1Data;
	logic [XLEN-1:0] rs2Data;
	logic [XLEN-1:0] aluB;
	logic [XLEN-1:0] aluResult;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] load;
	logic [XLEN-1:0] wrData;
	logic negative;
	logic zero;
	logic retire;

	assign aluB = ctrl.aluSrc ? ctrl.imm : rs2Data;

	instrDecoder i_instrDecoder (
		.instr_i(instr),
		.ctrl_o(ctrl)
	);

	alu i_alu (
		.a_i(rs1Data),
		.b_i(aluB),
		.op_i(ctrl.aluOp),
		.result_o(aluResult),
		.negative_o(negative),
		.zero_o(zero)
	);

	regFile i_regFile (
		.clk(clk),
		.nRST(nRST),
		.retire_i(retire),
		.ctrl_i(ctrl),
		.wrData_i(wrData),
		.rs1Data_o(rs1Data),
		.rs2Data_o(rs2Data)
	);

	pcUnit #(
		.RESET_PC(RESET_PC)
	) i_pcUnit (
		.clk(clk),
		.nRST(nRST),
		.enable_i(enable_i),
		.retire_i(retire),
		.ctrl_i(ctrl),
		.rs1Data_i(rs1Data),
		.negative_i(negative),
		.zero_i(zero),
		.pc_o(pc)
	);

	writeBack i_writeBack (
		.ctrl_i(ctrl),
		.aluResult_i(aluResult),
		.load_i(load),
		.pc_i(pc),
		.wrData_o(wrData)
	);

	coreSequencer #(
		.DATA_BASE(DATA_BASE)
	) i_coreSequencer (
		.clk(clk),
		.nRST(nRST),
		.enable_i(enable_i),
		.pc_i(pc),
		.ctrl_i(ctrl),
		.aluResult_i(aluResult),
		.storeData_i(rs2Data),
		.rsp_i(rsp),
		.req_o(req),
		.instr_o(instr),
		.load_o(load),
		.retire_o(retire),
		.halted_o(halted_o)
	);

	wbManager i_wbManager (
		.clk(clk),
		.nRST(nRST),
		.req_i(req),
		.datI_i(datI_i),
		.ackI_i(ackI_i),
		.rsp_o(rsp),
		.wb_o(wb_o)
	);

endmodule

//--- sim/rvCore_props.sv
`timescale 1ns/1ps

module rvCoreProps
	import rvPkg::*;
(
	input logic clk,
	input logic nRST,
	input wbMasterT wb_i,
	input logic ackI_i
);

	int failures = 0; // Read by the testbench when the run ends.

	stbNeedsCyc: assert property (@(posedge clk) disable iff (!nRST) wb_i.stb |-> wb_i.cyc)
		else begin
			failures++;
			$error("stb is high while cyc is low");
		end

	// A bus cycle without ack must keep address, data and byte selects steady.
	heldWhileWaiting: assert property (@(posedge clk) disable iff (!nRST)
		(wb_i.stb && !ackI_i) |=> ($stable(wb_i.adr) && $stable(wb_i.dat) && $stable(wb_i.sel)))
		else begin
			failures++;
			$error("bus outputs changed before ack");
		end

	weNeedsStb: assert property (@(posedge clk) disable iff (!nRST) wb_i.we |-> wb_i.stb)
		else begin
			failures++;
			$error("we is high while stb is low");
		end

endmodule

bind wbManager rvCoreProps i_rvCoreProps (
	.clk(clk),
	.nRST(nRST),
	.wb_i(wb_o),
	.ackI_i(ackI_i)
);

//--- sim/rvCoreTb.sv
`timescale 1ns/1ps

module rvCoreTb
	import rvPkg::*;
();

	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;
	localparam logic [XLEN-1:0] DATA_BASE = 32'h0000_2000;
	localparam int MEM_WORDS = 16384;
	localparam int INSTR_TOTAL = 200;
	localparam int CYCLES_PER_INSTR = 24; // Fetch and data access, each with a four-cycle ack delay.
	localparam int CYCLE_LIMIT = INSTR_TOTAL * CYCLES_PER_INSTR + 1000;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_LUI = 7'b0110111;

	logic clk;
	logic nRST;
	logic enable_i;
	logic [XLEN-1:0] datI_i;
	logic ackI_i;
	wbMasterT wb_o;
	logic halted_o;

	logic [XLEN-1:0] mem [MEM_WORDS];
	logic [XLEN-1:0] prog [$];
	logic [XLEN-1:0] expAdr [$];
	logic [XLEN-1:0] expDat [$];
	wbMasterT writeLog [$];
	wbMasterT readLog [$];
	wbMasterT refLog [$];
	wbMasterT snapshot;
	logic [11:0] storeOff;
	bit randomAckEn = 1'b0;
	bit busActive = 1'b0;
	int waitLeft = 0;
	int waitCycles = 0;
	int cycleCount = 0;
	int checkCount = 0;
	int errorCount = 0;
	int testErrors = 0;
	int testCount = 0;
	string curTest = "reset";

	rvCore #(
		.RESET_PC(RESET_PC),
		.DATA_BASE(DATA_BASE)
	) i_rvCore (
		.clk(clk),
		.nRST(nRST),
		.enable_i(enable_i),
		.datI_i(datI_i),
		.ackI_i(ackI_i),
		.wb_o(wb_o),
		.halted_o(halted_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > CYCLE_LIMIT) begin
			$display("%s: the run did not finish within %0d cycles", curTest, CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Bus memory. It answers each cycle after a chosen delay and logs every access.
	always @(posedge clk) begin
		#1;
		if (ackI_i) begin
			ackI_i = 1'b0;
			busActive = 1'b0;
		end else if (wb_o.cyc && wb_o.stb) begin
			if (!busActive) begin
				busActive = 1'b1;
				snapshot = wb_o;
				waitLeft = randomAckEn ? int'($urandom % 5) : 0;
			end else begin
				compareMaster("held bus outputs", snapshot, wb_o);
			end
			if (waitLeft == 0) begin
				ackI_i = 1'b1;
				if (wb_o.we) begin
					mem[wb_o.adr[15:2]] = wb_o.dat;
					writeLog.push_back(wb_o);
				end else begin
					datI_i = mem[wb_o.adr[15:2]];
					readLog.push_back(wb_o);
				end
			end else begin
				waitLeft--;
				waitCycles++;
			end
		end
	end

	task automatic reportError(input string what, input logic [XLEN-1:0] exp,
		input logic [XLEN-1:0] act);
		errorCount++;
		testErrors++;
		$display("** Error %s, %s: expected %h, actual %h", curTest, what, exp, act);
	endtask

	task automatic compareWord(input string what, input logic [XLEN-1:0] exp,
		input logic [XLEN-1:0] act);
		checkCount++;
		if (act !== exp)
			reportError(what, exp, act);
	endtask

	task automatic compareMaster(input string what, input wbMasterT exp, input wbMasterT act);
		checkCount++;
		if (act !== exp) begin
			errorCount++;
			testErrors++;
			$display("** Error %s, %s: expected %h, actual %h", curTest, what, exp, act);
		end
	endtask

	task automatic compareBit(input string what, input logic exp, input logic act);
		checkCount++;
		if (act !== exp) begin
			errorCount++;
			testErrors++;
			$display("** Error %s, %s: expected %b, actual %b", curTest, what, exp, act);
		end
	endtask

	function automatic logic [XLEN-1:0] encR(input logic [6:0] f7, input regIdxT rs2,
		input regIdxT rs1, input logic [2:0] f3, input regIdxT rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [XLEN-1:0] encI(input logic [11:0] imm, input regIdxT rs1,
		input logic [2:0] f3, input regIdxT rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [XLEN-1:0] encS(input logic [11:0] imm, input regIdxT rs2,
		input regIdxT rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [XLEN-1:0] encB(input logic [12:0] imm, input regIdxT rs2,
		input regIdxT rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [XLEN-1:0] encJ(input logic [20:0] imm, input regIdxT rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [XLEN-1:0] pcNow();
		return RESET_PC + XLEN'(4 * prog.size());
	endfunction

	// Branches compare through a subtract; the unsigned forms also look at its sign.
	function automatic logic branchTaken(input logic [2:0] f3, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b);
		logic [XLEN-1:0] diff;
		diff = a - b;
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100, 3'b110: return diff[XLEN-1];
			default: return !diff[XLEN-1];
		endcase
	endfunction

	task automatic storeAt(input logic [2:0] f3, input regIdxT rs2, input logic [XLEN-1:0] value,
		input bit expectIt);
		prog.push_back(encS(storeOff, rs2, 5'd0, f3));
		if (expectIt) begin
			expAdr.push_back(DATA_BASE + XLEN'(storeOff));
			expDat.push_back(value); // Every store writes the whole word.
		end
		storeOff = storeOff + 12'd4;
	endtask

	task automatic opCase(input logic [XLEN-1:0] instr, input logic [XLEN-1:0] value);
		prog.push_back(instr);
		storeAt(3'b010, 5'd4, value, 1'b1);
	endtask

	task automatic branchCase(input logic [2:0] f3, input regIdxT rs1, input regIdxT rs2,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		prog.push_back(encB(13'd8, rs2, rs1, f3));
		storeAt(3'b010, 5'd10, 32'h0000_005A, !branchTaken(f3, a, b));
	endtask

	task automatic startTest(input string name);
		curTest = name;
		testErrors = 0;
		prog.delete();
		expAdr.delete();
		expDat.delete();
		storeOff = 12'h040;
	endtask

	task automatic finishTest();
		testCount++;
		$display("%s finished with %0d error(s)", curTest, testErrors);
	endtask

	task automatic loadProgram();
		int base;
		base = int'(RESET_PC[15:2]);
		foreach (prog[i])
			mem[base + i] = prog[i];
		mem[base + prog.size()] = HALT_WORD;
	endtask

	task automatic runProgram(input bit randomAck);
		@(posedge clk);
		#1 enable_i = 1'b0;
		repeat (2) @(posedge clk);
		writeLog.delete();
		readLog.delete();
		randomAckEn = randomAck;
		#1 enable_i = 1'b1;
		@(negedge clk);
		while (halted_o !== 1'b1)
			@(negedge clk);
	endtask

	task automatic checkWrites();
		compareWord("write count", XLEN'(expAdr.size()), XLEN'(writeLog.size()));
		for (int i = 0; i < expAdr.size() && i < writeLog.size(); i++) begin
			compareWord("store address", expAdr[i], writeLog[i].adr);
			compareWord("store data", expDat[i], writeLog[i].dat);
			compareWord("byte selects", 32'h0000_000F, XLEN'(writeLog[i].sel));
		end
	endtask

	task automatic buildAluProgram();
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		a = 32'hFFFF_FB2E; // -1234
		b = 32'h0000_004D;
		prog.push_back(encI(a[11:0], 5'd0, 3'b000, 5'd1, OP_IMM));
		prog.push_back(encI(b[11:0], 5'd0, 3'b000, 5'd2, OP_IMM));
		prog.push_back(encI(12'd35, 5'd0, 3'b000, 5'd5, OP_IMM)); // Only the low five bits shift.
		opCase(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), a + b);
		opCase(encR(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), a - b);
		opCase(encR(7'h00, 5'd2, 5'd1, 3'b100, 5'd4), a ^ b);
		opCase(encR(7'h00, 5'd2, 5'd1, 3'b110, 5'd4), a | b);
		opCase(encR(7'h00, 5'd2, 5'd1, 3'b111, 5'd4), a & b);
		opCase(encR(7'h00, 5'd5, 5'd2, 3'b001, 5'd4), b << 3);
		opCase(encR(7'h00, 5'd5, 5'd1, 3'b101, 5'd4), a >> 3);
		opCase(encR(7'h20, 5'd5, 5'd1, 3'b101, 5'd4), $signed(a) >>> 3);
		opCase(encR(7'h00, 5'd2, 5'd1, 3'b010, 5'd4), {31'b0, $signed(a) < $signed(b)});
		opCase(encR(7'h00, 5'd2, 5'd1, 3'b011, 5'd4), {31'b0, a < b});
		opCase(encI(12'hFFB, 5'd1, 3'b000, 5'd4, OP_IMM), a + 32'hFFFF_FFFB);
		opCase(encI(12'h0F0, 5'd1, 3'b100, 5'd4, OP_IMM), a ^ 32'h0000_00F0);
		opCase(encI(12'h123, 5'd1, 3'b110, 5'd4, OP_IMM), a | 32'h0000_0123);
		opCase(encI(12'h7FF, 5'd1, 3'b111, 5'd4, OP_IMM), a & 32'h0000_07FF);
		opCase(encI(12'h004, 5'd1, 3'b001, 5'd4, OP_IMM), a << 4);
		opCase(encI(12'h007, 5'd1, 3'b101, 5'd4, OP_IMM), a >> 7);
		opCase(encI(12'h407, 5'd1, 3'b101, 5'd4, OP_IMM), $signed(a) >>> 7);
		opCase(encI(12'h830, 5'd1, 3'b010, 5'd4, OP_IMM), {31'b0, $signed(a) < -2000});
		opCase(encI(12'h064, 5'd2, 3'b011, 5'd4, OP_IMM), {31'b0, b < 32'd100});
	endtask

	task automatic resetStart();
		startTest("resetStart");
		@(negedge clk);
		compareMaster("bus outputs after reset", '0, wb_o);
		compareBit("halted after reset", 1'b0, halted_o);
		loadProgram();
		runProgram(1'b0);
		if (readLog.size() == 0) begin
			errorCount++;
			testErrors++;
			$display("%s: no bus read was issued after enable", curTest);
		end else begin
			compareWord("first fetch address", RESET_PC, readLog[0].adr);
		end
		finishTest();
	endtask

	task automatic aluOps();
		startTest("aluOps");
		buildAluProgram();
		loadProgram();
		runProgram(1'b0);
		checkWrites();
		refLog = writeLog;
		finishTest();
	endtask

	task automatic loadsStores();
		logic [XLEN-1:0] w0;
		logic [XLEN-1:0] w1;
		startTest("loadsStores");
		w0 = 32'h8F6E_A5C3;
		w1 = 32'h1234_5678;
		mem[(DATA_BASE[15:2] + 14'h100)] = w0;
		mem[(DATA_BASE[15:2] + 14'h101)] = w1;
		prog.push_back(encI(12'h400, 5'd0, 3'b000, 5'd6, OP_IMM));
		opCase(encI(12'h000, 5'd6, 3'b000, 5'd4, OP_LOAD), {{24{w0[7]}}, w0[7:0]});
		opCase(encI(12'h000, 5'd6, 3'b001, 5'd4, OP_LOAD), {{16{w0[15]}}, w0[15:0]});
		opCase(encI(12'h000, 5'd6, 3'b010, 5'd4, OP_LOAD), w0);
		opCase(encI(12'h000, 5'd6, 3'b100, 5'd4, OP_LOAD), {24'b0, w0[7:0]});
		opCase(encI(12'h000, 5'd6, 3'b101, 5'd4, OP_LOAD), {16'b0, w0[15:0]});
		opCase(encI(12'h004, 5'd6, 3'b000, 5'd4, OP_LOAD), {{24{w1[7]}}, w1[7:0]});
		opCase(encI(12'h004, 5'd6, 3'b001, 5'd4, OP_LOAD), {{16{w1[15]}}, w1[15:0]});
		opCase(encI(12'h004, 5'd6, 3'b100, 5'd4, OP_LOAD), {24'b0, w1[7:0]});
		prog.push_back(encI(12'h000, 5'd6, 3'b010, 5'd8, OP_LOAD));
		storeAt(3'b000, 5'd8, w0, 1'b1);
		storeAt(3'b001, 5'd8, w0, 1'b1);
		prog.push_back(encS(12'hFFC, 5'd8, 5'd6, 3'b010)); // Negative offset from a base register.
		expAdr.push_back(DATA_BASE + 32'h0000_03FC);
		expDat.push_back(w0);
		loadProgram();
		runProgram(1'b0);
		checkWrites();
		finishTest();
	endtask

	task automatic controlFlow();
		logic [XLEN-1:0] linkPc;
		startTest("controlFlow");
		prog.push_back(encI(12'd5, 5'd0, 3'b000, 5'd1, OP_IMM));
		prog.push_back(encI(12'hFFD, 5'd0, 3'b000, 5'd2, OP_IMM));
		prog.push_back(encI(12'd5, 5'd0, 3'b000, 5'd3, OP_IMM));
		prog.push_back(encI(12'd2, 5'd0, 3'b000, 5'd4, OP_IMM));
		prog.push_back(encI(12'h05A, 5'd0, 3'b000, 5'd10, OP_IMM));
		branchCase(3'b000, 5'd1, 5'd3, 32'd5, 32'd5);
		branchCase(3'b000, 5'd1, 5'd2, 32'd5, 32'hFFFF_FFFD);
		branchCase(3'b001, 5'd1, 5'd2, 32'd5, 32'hFFFF_FFFD);
		branchCase(3'b001, 5'd1, 5'd3, 32'd5, 32'd5);
		branchCase(3'b100, 5'd2, 5'd1, 32'hFFFF_FFFD, 32'd5);
		branchCase(3'b100, 5'd1, 5'd2, 32'd5, 32'hFFFF_FFFD);
		branchCase(3'b101, 5'd1, 5'd2, 32'd5, 32'hFFFF_FFFD);
		branchCase(3'b101, 5'd2, 5'd1, 32'hFFFF_FFFD, 32'd5);
		branchCase(3'b110, 5'd4, 5'd1, 32'd2, 32'd5);
		branchCase(3'b110, 5'd1, 5'd4, 32'd5, 32'd2);
		branchCase(3'b111, 5'd1, 5'd4, 32'd5, 32'd2);
		branchCase(3'b111, 5'd4, 5'd1, 32'd2, 32'd5);
		prog.push_back(encI(12'd3, 5'd0, 3'b000, 5'd11, OP_IMM));
		prog.push_back(encI(12'd0, 5'd0, 3'b000, 5'd12, OP_IMM));
		prog.push_back(encI(12'd7, 5'd12, 3'b000, 5'd12, OP_IMM));
		prog.push_back(encI(12'hFFF, 5'd11, 3'b000, 5'd11, OP_IMM));
		prog.push_back(encB(13'h1FF8, 5'd0, 5'd11, 3'b001)); // Back to the first add of the loop.
		storeAt(3'b010, 5'd12, 32'd3 * 32'd7, 1'b1);
		linkPc = pcNow();
		prog.push_back(encJ(21'd12, 5'd13));
		storeAt(3'b010, 5'd10, 32'h0000_005A, 1'b0);
		storeAt(3'b010, 5'd10, 32'h0000_005A, 1'b0);
		storeAt(3'b010, 5'd13, linkPc + 32'd4, 1'b1);
		linkPc = pcNow();
		prog.push_back({20'h0, 5'd15, OP_AUIPC});
		prog.push_back(encI(12'd16, 5'd15, 3'b000, 5'd16, OP_JALR));
		storeAt(3'b010, 5'd10, 32'h0000_005A, 1'b0);
		storeAt(3'b010, 5'd10, 32'h0000_005A, 1'b0);
		storeAt(3'b010, 5'd16, linkPc + 32'd8, 1'b1);
		storeAt(3'b010, 5'd15, linkPc, 1'b1);
		linkPc = pcNow();
		prog.push_back({20'h00001, 5'd18, OP_AUIPC});
		storeAt(3'b010, 5'd18, linkPc + 32'h0000_1000, 1'b1);
		prog.push_back({20'hABCDE, 5'd17, OP_LUI});
		storeAt(3'b010, 5'd17, 32'hABCD_E000, 1'b1);
		loadProgram();
		runProgram(1'b0);
		checkWrites();
		finishTest();
	endtask

	task automatic backPressure();
		startTest("backPressure");
		buildAluProgram();
		loadProgram();
		waitCycles = 0;
		runProgram(1'b1);
		checkWrites();
		compareWord("write count against zero-wait run", XLEN'(refLog.size()),
			XLEN'(writeLog.size()));
		for (int i = 0; i < refLog.size() && i < writeLog.size(); i++) begin
			compareWord("address order", refLog[i].adr, writeLog[i].adr);
			compareWord("data order", refLog[i].dat, writeLog[i].dat);
		end
		compareBit("ack delays applied", 1'b1, waitCycles != 0);
		finishTest();
	endtask

	task automatic haltStop();
		logic sawCyc;
		startTest("haltStop");
		sawCyc = 1'b0;
		prog.push_back(encI(12'h033, 5'd0, 3'b000, 5'd9, OP_IMM));
		storeAt(3'b010, 5'd9, 32'h0000_0033, 1'b1);
		loadProgram();
		runProgram(1'b0);
		checkWrites();
		repeat (50) begin
			@(negedge clk);
			if (wb_o.cyc)
				sawCyc = 1'b1;
		end
		compareBit("bus cycle after halt", 1'b0, sawCyc);
		compareBit("halted at end of window", 1'b1, halted_o);
		finishTest();
	endtask

	initial begin
		void'($urandom(56));
		nRST = 1'b0;
		enable_i = 1'b0;
		datI_i = '0;
		ackI_i = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = 32'hC000_0000 | (XLEN'(i) << 2);
		repeat (16) @(posedge clk);
		#1 nRST = 1'b1;
		resetStart();
		aluOps();
		loadsStores();
		controlFlow();
		backPressure();
		haltStop();
		$display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d", testCount,
			checkCount, errorCount, i_rvCore.i_wbManager.i_rvCoreProps.failures);
		if (errorCount == 0 && i_rvCore.i_wbManager.i_rvCoreProps.failures == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- vlog.f
common/rvPkg.sv
verilog/instrDecoder.sv
verilog/alu.sv
verilog/regFile.sv
verilog/pcUnit.sv
verilog/writeBack.sv
bus/coreSequencer.sv
bus/wbManager.sv
verilog/rvCore.sv
sim/rvCore_props.sv
sim/rvCoreTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the log.
verilator --binary --timing --assert --top-module rvCoreTb -f vlog.f -o rvCoreSim \
	&& ./obj_dir/rvCoreSim +verilator+error+limit+1000 > sim.log 2>&1 ; cat sim.log \
	&& grep -q "^TEST PASSED$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
